// File: logic/dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

////////////////////
// Cache geometry
////////////////////

`define DCACHE_WAYS 4
`define DCACHE_SETS 16

// Words per line
`define DCACHE_LINE_WORDS 16

// Address is tag | index | word offset | byte offset
`define DCACHE_TAG_W 22
`define DCACHE_INDEX_W 4
`define DCACHE_OFFSET_W 4

`endif

// File: logic/dcache_pkg.sv
`default_nettype none

`include "dcache_settings.svh"

package dcache_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [`DCACHE_TAG_W-1:0] tag_t;
  typedef logic [`DCACHE_INDEX_W-1:0] index_t;
  typedef logic [`DCACHE_OFFSET_W-1:0] offset_t;
  typedef logic [$clog2(`DCACHE_WAYS)-1:0] way_t;
  typedef logic [1:0] age_t;   // 0 is most recent
  typedef logic [3:0] byte_en_t;

  typedef word_t [`DCACHE_LINE_WORDS-1:0] line_t;

  typedef struct packed {
    logic valid;
    logic dirty;
    tag_t tag;
  } tag_entry_t;

  ////////////////////
  // Address fields
  ////////////////////

  function automatic tag_t addr_tag(addr_t a);
    return a[31 -: `DCACHE_TAG_W];
  endfunction

  function automatic index_t addr_index(addr_t a);
    return a[`DCACHE_OFFSET_W + 2 +: `DCACHE_INDEX_W];
  endfunction

  function automatic offset_t addr_offset(addr_t a);
    return a[2 +: `DCACHE_OFFSET_W];  // Skip byte bits
  endfunction

endpackage

`default_nettype wire

// File: logic/line_buf_if.sv
`default_nettype none

interface line_buf_if;
  import dcache_pkg::*;

  logic    load;         // Capture load_line
  line_t   load_line;
  logic    beat_active;
  logic    write_back;   // Low for refill
  offset_t beat_idx;
  logic    last_beat;
  word_t   word_out;
  line_t   line_out;

  modport ctrl (output load, load_line, beat_active, write_back,
                input  last_beat, line_out);

  modport counter (input beat_active, output beat_idx, last_beat);

  modport buffer (input  load, load_line, beat_active, write_back, beat_idx,
                  output word_out, line_out);

endinterface

`default_nettype wire

// File: logic/set_ram.sv
`default_nettype none

`include "dcache_settings.svh"

module set_ram #(
  parameter type payload_t = dcache_pkg::word_t
) (
  input  wire                clk,
  input  wire                rst,
  input  wire dcache_pkg::index_t rd_index,
  output payload_t           rd_data,
  input  wire                wr_en,
  input  wire dcache_pkg::index_t wr_index,
  input  wire payload_t      wr_data
);

  payload_t mem [`DCACHE_SETS];

  // One cycle read latency
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < `DCACHE_SETS; i++)
        mem[i] <= '0;
      rd_data <= '0;
    end
    else
    begin
      if (wr_en)
        mem[wr_index] <= wr_data;
      rd_data <= mem[rd_index];  // Old data on same-index write
    end
  end

endmodule

`default_nettype wire

// File: logic/lru_table.sv
`default_nettype none

`include "dcache_settings.svh"

module lru_table (
  input  wire                      clk,
  input  wire                      rst,
  input  wire dcache_pkg::index_t  index,
  input  wire                      touch,
  input  wire dcache_pkg::way_t    touch_way,
  input  wire [`DCACHE_WAYS-1:0]   valid_ways,
  output dcache_pkg::way_t         victim
);
  import dcache_pkg::*;

  age_t ages [`DCACHE_SETS][`DCACHE_WAYS];
  age_t old_age;
  age_t best_age;
  logic found;

  assign old_age = ages[index][touch_way];

  ////////////////////
  // Age update
  ////////////////////

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int s = 0; s < `DCACHE_SETS; s++)
        for (int w = 0; w < `DCACHE_WAYS; w++)
          ages[s][w] <= '0;
    end
    else if (touch)
    begin
      for (int w = 0; w < `DCACHE_WAYS; w++)
      begin
        if (way_t'(w) == touch_way)
          ages[index][w] <= '0;
        else if (ages[index][w] <= old_age && ages[index][w] != 2'd3)
          ages[index][w] <= ages[index][w] + 2'd1;  // Saturate at 3
      end
    end
  end

  // Invalid way first, else the oldest with lowest number on ties
  always_comb
  begin
    found    = 1'b0;
    victim   = '0;
    best_age = ages[index][0];
    for (int w = 0; w < `DCACHE_WAYS; w++)
    begin
      if (!valid_ways[w] && !found)
      begin
        victim = way_t'(w);
        found  = 1'b1;
      end
    end
    if (!found)
    begin
      for (int w = 1; w < `DCACHE_WAYS; w++)
      begin
        if (ages[index][w] > best_age)
        begin
          best_age = ages[index][w];
          victim   = way_t'(w);
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/beat_counter.sv
`default_nettype none

`include "dcache_settings.svh"

module beat_counter (
  input  wire        clk,
  input  wire        rst,
  input  wire        beat_ok,
  line_buf_if.counter lb
);
  import dcache_pkg::*;

  offset_t idx;

  // Wraps 15 to 0, so a write-back runs straight into the refill
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      idx <= '0;
    else if (!lb.beat_active)
      idx <= '0;
    else if (beat_ok)
      idx <= idx + 1'b1;
  end

  assign lb.beat_idx = idx;

  // Final word of the burst
  assign lb.last_beat = lb.beat_active &&
                        (idx == offset_t'(`DCACHE_LINE_WORDS - 1));

endmodule

`default_nettype wire

// File: logic/line_buffer.sv
`default_nettype none

module line_buffer (
  input  wire                     clk,
  input  wire                     rst,
  input  wire dcache_pkg::word_t  sdata,
  input  wire                     beat_ok,
  line_buf_if.buffer              lb
);
  import dcache_pkg::*;

  line_t buf_q;
  logic  refill_beat;

  assign refill_beat = lb.beat_active && !lb.write_back && beat_ok;

  ////////////////////
  // Line storage
  ////////////////////

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      buf_q <= '0;
    else if (lb.load)
      buf_q <= lb.load_line;  // Victim line from the data RAM
    else if (refill_beat)
      buf_q[lb.beat_idx] <= sdata;
  end

  // Word for the current write-back beat
  assign lb.word_out = buf_q[lb.beat_idx];

  // Assembled refill line
  assign lb.line_out = buf_q;

endmodule

`default_nettype wire

// File: logic/dcache_ctrl.sv
`default_nettype none

`include "dcache_settings.svh"

module dcache_ctrl (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         req,
  input  wire                         wreq,
  input  wire dcache_pkg::addr_t      insaddr,
  input  wire dcache_pkg::word_t      din,
  input  wire dcache_pkg::byte_en_t   wbyte,
  output logic                        ok,
  output logic                        miss,
  output dcache_pkg::word_t           ins,
  input  wire dcache_pkg::tag_entry_t tag_rd [`DCACHE_WAYS],
  input  wire dcache_pkg::line_t      line_rd [`DCACHE_WAYS],
  input  wire dcache_pkg::way_t       victim,
  output logic [`DCACHE_WAYS-1:0]     tag_we,
  output logic [`DCACHE_WAYS-1:0]     data_we,
  output dcache_pkg::tag_entry_t      tag_wr,
  output dcache_pkg::line_t           line_wr,
  output logic                        touch,
  output dcache_pkg::way_t            touch_way,
  output logic                        sen,
  output logic                        wen,
  output dcache_pkg::addr_t           raddr,
  output dcache_pkg::addr_t           waddr,
  input  wire                         rdata_ok,
  input  wire                         wdata_ok,
  line_buf_if.ctrl                    lb
);
  import dcache_pkg::*;

  typedef enum logic [2:0] {IDLE, LOOKUP, WRITE_BACK, REFILL, INSTALL, DONE} state_t;

  state_t  state, state_nx;
  tag_t    req_tag;
  index_t  req_index;
  offset_t req_offset;
  logic [`DCACHE_WAYS-1:0] hit_vec;
  logic    hit;
  way_t    hit_way;
  way_t    way_q;
  tag_t    wb_tag;
  logic    miss_q;
  word_t   ins_q;
  line_t   src_line;
  line_t   merged_line;

  // CPU holds the address until ok
  assign req_tag    = addr_tag(insaddr);
  assign req_index  = addr_index(insaddr);
  assign req_offset = addr_offset(insaddr);

  ////////////////////
  // Tag compare
  ////////////////////

  always_comb
  begin
    hit_vec = '0;
    hit_way = '0;
    for (int w = 0; w < `DCACHE_WAYS; w++)
    begin
      hit_vec[w] = tag_rd[w].valid && (tag_rd[w].tag == req_tag);
      if (hit_vec[w])
        hit_way = way_t'(w);
    end
  end

  assign hit = |hit_vec;

  // Byte merge into the hit line or the refilled line
  always_comb
  begin
    src_line    = (state == INSTALL) ? lb.line_out : line_rd[hit_way];
    merged_line = src_line;
    for (int b = 0; b < 4; b++)
    begin
      if (wreq && wbyte[b])
        merged_line[req_offset][8*b +: 8] = din[8*b +: 8];
    end
  end

  ////////////////////
  // FSM
  ////////////////////

  always_comb
  begin
    state_nx = state;
    case (state)
      IDLE:       if (req) state_nx = LOOKUP;
      LOOKUP:
      begin
        if (hit)
          state_nx = DONE;
        else if (tag_rd[victim].valid && tag_rd[victim].dirty)
          state_nx = WRITE_BACK;
        else
          state_nx = REFILL;
      end
      WRITE_BACK: if (wdata_ok && lb.last_beat) state_nx = REFILL;
      REFILL:     if (rdata_ok && lb.last_beat) state_nx = INSTALL;
      INSTALL:    state_nx = DONE;
      DONE:       state_nx = IDLE;   // One idle cycle before next request
      default:    state_nx = IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state  <= IDLE;
      way_q  <= '0;
      wb_tag <= '0;
      miss_q <= 1'b0;
      ins_q  <= '0;
    end
    else
    begin
      state <= state_nx;
      if (state == LOOKUP)
      begin
        way_q  <= hit ? hit_way : victim;
        wb_tag <= tag_rd[victim].tag;
        miss_q <= !hit;
      end
      else if (state == DONE)
        miss_q <= 1'b0;
      if ((state == LOOKUP && hit) || state == INSTALL)
        ins_q <= merged_line[req_offset];
    end
  end

  // RAM writes for a write hit or a line install
  always_comb
  begin
    tag_we  = '0;
    data_we = '0;
    if (state == LOOKUP && hit && wreq)
    begin
      tag_we[hit_way]  = 1'b1;
      data_we[hit_way] = 1'b1;
    end
    if (state == INSTALL)
    begin
      tag_we[way_q]  = 1'b1;
      data_we[way_q] = 1'b1;
    end
  end

  assign tag_wr    = '{valid: 1'b1, dirty: wreq, tag: req_tag};
  assign line_wr   = merged_line;
  assign ok        = (state == DONE);
  assign miss      = miss_q;
  assign ins       = ins_q;
  assign touch     = (state == DONE);
  assign touch_way = way_q;

  ////////////////////
  // Memory bursts
  ////////////////////

  assign sen   = (state == REFILL);
  assign wen   = (state == WRITE_BACK);
  assign raddr = {req_tag, req_index, {(`DCACHE_OFFSET_W + 2){1'b0}}};
  assign waddr = {wb_tag, req_index, {(`DCACHE_OFFSET_W + 2){1'b0}}};

  assign lb.load        = (state == LOOKUP) && !hit;  // Victim line into buffer
  assign lb.load_line   = line_rd[victim];
  assign lb.beat_active = sen || wen;
  assign lb.write_back  = wen;

endmodule

`default_nettype wire

// File: logic/dcache_top.sv
`default_nettype none

`include "dcache_settings.svh"

module dcache_top (
  input  wire                       clk,
  input  wire                       rst,
  // CPU side
  input  wire                       req,
  input  wire                       wreq,
  input  wire dcache_pkg::addr_t    insaddr,
  input  wire dcache_pkg::word_t    din,
  input  wire dcache_pkg::byte_en_t wbyte,
  output logic                      ok,
  output logic                      miss,
  output dcache_pkg::word_t         ins,
  // Memory side
  output logic                      sen,
  output dcache_pkg::addr_t         raddr,
  input  wire                       rdata_ok,
  input  wire dcache_pkg::word_t    sdata,
  output logic                      wen,
  output dcache_pkg::addr_t         waddr,
  output dcache_pkg::word_t         wdata,
  input  wire                       wdata_ok
);
  import dcache_pkg::*;

  tag_entry_t              tag_rd [`DCACHE_WAYS];
  line_t                   line_rd [`DCACHE_WAYS];
  logic [`DCACHE_WAYS-1:0] tag_we;
  logic [`DCACHE_WAYS-1:0] data_we;
  logic [`DCACHE_WAYS-1:0] valid_ways;
  tag_entry_t              tag_wr;
  line_t                   line_wr;
  way_t                    victim;
  way_t                    touch_way;
  logic                    touch;
  logic                    beat_ok;
  index_t                  set_index;

  line_buf_if lb ();

  assign set_index = addr_index(insaddr);
  assign beat_ok   = rdata_ok | wdata_ok;
  assign wdata     = lb.word_out;

  ////////////////////
  // Ways
  ////////////////////

  for (genvar w = 0; w < `DCACHE_WAYS; w++)
  begin : g_way
    set_ram #(.payload_t(tag_entry_t)) u_tag (
      .clk(clk), .rst(rst), .rd_index(set_index), .rd_data(tag_rd[w]),
      .wr_en(tag_we[w]), .wr_index(set_index), .wr_data(tag_wr));

    set_ram #(.payload_t(line_t)) u_data (
      .clk(clk), .rst(rst), .rd_index(set_index), .rd_data(line_rd[w]),
      .wr_en(data_we[w]), .wr_index(set_index), .wr_data(line_wr));

    assign valid_ways[w] = tag_rd[w].valid;
  end

  lru_table u_lru (
    .clk(clk), .rst(rst), .index(set_index), .touch(touch),
    .touch_way(touch_way), .valid_ways(valid_ways), .victim(victim));

  dcache_ctrl u_ctrl (
    .clk(clk), .rst(rst), .req(req), .wreq(wreq), .insaddr(insaddr),
    .din(din), .wbyte(wbyte), .ok(ok), .miss(miss), .ins(ins),
    .tag_rd(tag_rd), .line_rd(line_rd), .victim(victim),
    .tag_we(tag_we), .data_we(data_we), .tag_wr(tag_wr), .line_wr(line_wr),
    .touch(touch), .touch_way(touch_way), .sen(sen), .wen(wen),
    .raddr(raddr), .waddr(waddr), .rdata_ok(rdata_ok), .wdata_ok(wdata_ok),
    .lb(lb));

  beat_counter u_beats (.clk(clk), .rst(rst), .beat_ok(beat_ok), .lb(lb));

  line_buffer u_buf (.clk(clk), .rst(rst), .sdata(sdata), .beat_ok(beat_ok), .lb(lb));

endmodule

`default_nettype wire

// File: dv/mem_model.sv
`default_nettype none

module mem_model #(
  parameter logic [31:0] SEED = 32'hf73639d8
) (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    gap_en,
  input  wire                    sen,
  input  wire dcache_pkg::addr_t raddr,
  output logic                   rdata_ok,
  output dcache_pkg::word_t      sdata,
  input  wire                    wen,
  input  wire dcache_pkg::addr_t waddr,
  input  wire dcache_pkg::word_t wdata,
  output logic                   wdata_ok,
  input  wire dcache_pkg::addr_t peek_addr,
  output dcache_pkg::word_t      peek_data
);
  import dcache_pkg::*;

  word_t       mem [65536];   // 256 KB window
  logic [31:0] lcg_state;
  int          rcount;
  int          wcount;

  function automatic word_t fill_word(addr_t a);
    return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]} ^ 32'h3c3ca5a5;
  endfunction

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Roughly one beat in four stalls when gaps are on
  function automatic logic beat_go();
    logic [31:0] r;
    if (!gap_en)
      return 1'b1;
    r = lcg_next();
    return r[5:4] != 2'b00;
  endfunction

  assign peek_data = mem[peek_addr[17:2]];

  initial
  begin
    logic  nxt_r;
    logic  nxt_w;
    addr_t raddr_s;
    for (int i = 0; i < 65536; i++)
      mem[i] = fill_word(addr_t'(i) << 2);
    lcg_state = SEED;
    rdata_ok  = 1'b0;
    wdata_ok  = 1'b0;
    sdata     = '0;
    rcount    = 0;
    wcount    = 0;
    forever
    begin
      @(posedge clk);
      raddr_s = raddr;
      if (wen && wdata_ok)
      begin
        mem[16'((waddr >> 2) + addr_t'(wcount))] = wdata;
        wcount++;
      end
      if (sen && rdata_ok)
        rcount++;
      if (!wen)
        wcount = 0;
      if (!sen)
        rcount = 0;
      nxt_w = wen && (wcount < 16) && beat_go();
      nxt_r = sen && (rcount < 16) && beat_go();
      #2;
      if (rst)
      begin
        rdata_ok = 1'b0;
        wdata_ok = 1'b0;
        sdata    = '0;
      end
      else
      begin
        wdata_ok = nxt_w;
        rdata_ok = nxt_r;
        sdata    = nxt_r ? mem[16'((raddr_s >> 2) + addr_t'(rcount))] : '0;
      end
    end
  end

endmodule

`default_nettype wire

// File: dv/tb_dcache.sv
`default_nettype none

`include "dcache_settings.svh"

module tb_dcache;
  import dcache_pkg::*;

  localparam int NUM_REQ = 1 + 1 + 2 + 5 + 13 + 60;
  localparam int TIMEOUT = NUM_REQ * 40 * 40;

  logic clk, rst, req, wreq, ok, miss, sen, wen, rdata_ok, wdata_ok, gap_en;
  addr_t insaddr, raddr, waddr, peek_addr;
  word_t din, ins, sdata, wdata, peek_data;
  byte_en_t wbyte;

  int errors, checks, wb_count;
  logic last_sen;
  logic last_wen;
  logic [31:0] lcg_state;

  // Golden memory and cache model
  word_t gold [65536];
  logic  ref_valid [`DCACHE_SETS][`DCACHE_WAYS];
  logic  ref_dirty [`DCACHE_SETS][`DCACHE_WAYS];
  tag_t  ref_tag [`DCACHE_SETS][`DCACHE_WAYS];
  age_t  ref_age [`DCACHE_SETS][`DCACHE_WAYS];

  dcache_top DUT (
    .clk(clk), .rst(rst), .req(req), .wreq(wreq), .insaddr(insaddr), .din(din),
    .wbyte(wbyte), .ok(ok), .miss(miss), .ins(ins), .sen(sen), .raddr(raddr),
    .rdata_ok(rdata_ok), .sdata(sdata), .wen(wen), .waddr(waddr), .wdata(wdata),
    .wdata_ok(wdata_ok));

  mem_model u_mem (
    .clk(clk), .rst(rst), .gap_en(gap_en), .sen(sen), .raddr(raddr),
    .rdata_ok(rdata_ok), .sdata(sdata), .wen(wen), .waddr(waddr), .wdata(wdata),
    .wdata_ok(wdata_ok), .peek_addr(peek_addr), .peek_data(peek_data));

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic word_t expected_fill(addr_t a);
    return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]} ^ 32'h3c3ca5a5;
  endfunction

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic word_t merge_bytes(word_t old, word_t d, byte_en_t be);
    word_t r;
    r = old;
    for (int b = 0; b < 4; b++)
      if (be[b])
        r[8*b +: 8] = d[8*b +: 8];
    return r;
  endfunction

  ////////////////////
  // Reference model
  ////////////////////

  function automatic void ref_access(input addr_t a, input logic wr, output logic exp_miss,
                                     output logic wb, output addr_t wb_addr);
    logic [3:0] s;
    tag_t       t;
    int         way;
    logic       found;
    age_t       old;
    s = a[9:6];
    t = a[31:10];
    way = -1;
    for (int w = 0; w < `DCACHE_WAYS; w++)
      if (ref_valid[s][w] && ref_tag[s][w] == t)
        way = w;
    exp_miss = (way < 0);
    wb = 1'b0;
    wb_addr = '0;
    if (exp_miss)
    begin
      found = 1'b0;
      for (int w = 0; w < `DCACHE_WAYS; w++)
        if (!ref_valid[s][w] && !found)
        begin
          way = w;
          found = 1'b1;
        end
      if (!found)
      begin
        way = 0;
        for (int w = 1; w < `DCACHE_WAYS; w++)
          if (ref_age[s][w] > ref_age[s][way])
            way = w;
      end
      wb = ref_valid[s][way] && ref_dirty[s][way];
      wb_addr = {ref_tag[s][way], s, 6'b0};
      ref_valid[s][way] = 1'b1;
      ref_tag[s][way] = t;
      ref_dirty[s][way] = 1'b0;
    end
    if (wr)
      ref_dirty[s][way] = 1'b1;
    old = ref_age[s][way];
    for (int w = 0; w < `DCACHE_WAYS; w++)
      if (w == way)
        ref_age[s][w] = '0;
      else if (ref_age[s][w] <= old && ref_age[s][w] != 2'd3)
        ref_age[s][w] = ref_age[s][w] + 2'd1;  // Saturates at 3
  endfunction

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_word(input string name, input word_t exp, input word_t act);
    checks++;
    if (exp !== act)
    begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_miss(input string name, input logic exp, input logic act);
    checks++;
    if (exp !== act)
    begin
      $display("CHECK FAILED %s miss: expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_mem(input string name, input addr_t a, input word_t exp);
    peek_addr = a;
    #1;
    checks++;
    if (exp !== peek_data)
    begin
      $display("CHECK FAILED %s mem[%h]: expected %h, actual %h", name, a, exp, peek_data);
      errors++;
    end
  endtask

  // One CPU request, compared against the model when ok arrives
  task automatic access(input string name, input logic wr, input addr_t a, input word_t d,
                        input byte_en_t be);
    logic  exp_miss;
    logic  wb;
    addr_t wb_addr;
    word_t got;
    logic  got_miss;
    ref_access(a, wr, exp_miss, wb, wb_addr);
    if (wr)
      gold[a[17:2]] = merge_bytes(gold[a[17:2]], d, be);
    @(posedge clk);
    #2;
    req = 1'b1;
    wreq = wr;
    insaddr = a;
    din = d;
    wbyte = be;
    last_sen = 1'b0;
    last_wen = 1'b0;
    do
    begin
      @(negedge clk);
      last_sen |= sen;
      last_wen |= wen;
    end
    while (!ok);
    got = ins;
    got_miss = miss;
    @(posedge clk);
    #2;
    req = 1'b0;
    wreq = 1'b0;
    check_word(name, gold[a[17:2]], got);
    check_miss(name, exp_miss, got_miss);
    if (last_wen)
      wb_count++;
    if (wb)
    begin
      for (int i = 0; i < `DCACHE_LINE_WORDS; i++)
        check_mem(name, wb_addr + addr_t'(4 * i), gold[wb_addr[17:2] + 16'(i)]);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("%s: %s", name, (errors == errs_before) ? "ok" : "FAILED");
  endtask

  initial
  begin
    #(TIMEOUT);
    $display("Watchdog expired, the run did not finish in time");
    $display("Test failures found");
    $finish;
  end

  initial
  begin
    int    e;
    int    wb_before;
    addr_t a;
    word_t r;
    rst = 1'b1;
    req = 1'b0;
    wreq = 1'b0;
    insaddr = '0;
    din = '0;
    wbyte = '0;
    gap_en = 1'b0;
    peek_addr = '0;
    errors = 0;
    checks = 0;
    wb_count = 0;
    lcg_state = 32'hf73639d8;
    for (int i = 0; i < 65536; i++)
      gold[i] = expected_fill(addr_t'(i) << 2);
    for (int s = 0; s < `DCACHE_SETS; s++)
      for (int w = 0; w < `DCACHE_WAYS; w++)
      begin
        ref_valid[s][w] = 1'b0;
        ref_dirty[s][w] = 1'b0;
        ref_tag[s][w] = '0;
        ref_age[s][w] = '0;
      end
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;
    @(negedge clk);
    if (ok || miss || sen || wen)
    begin
      $display("Outputs not low after reset");
      errors++;
    end

    e = errors;
    access("read_miss", 1'b0, 32'h0000_1040, '0, '0);
    report_test("read_miss", e);

    e = errors;
    access("read_hit", 1'b0, 32'h0000_1048, '0, '0);
    if (last_sen)
    begin
      $display("sen was raised during a read hit");
      errors++;
    end
    report_test("read_hit", e);

    e = errors;
    r = lcg_next();
    access("byte_write", 1'b1, 32'h0000_104c, lcg_next(), byte_en_t'(r[7:4]));
    access("byte_readback", 1'b0, 32'h0000_104c, '0, '0);
    report_test("byte_write", e);

    e = errors;
    wb_before = wb_count;
    for (int t = 1; t <= 5; t++)
      access($sformatf("write_back_%0d", t), 1'b1, addr_t'((t << 10) | (2 << 6) | 4),
             lcg_next(), 4'hf);
    if (wb_count == wb_before)
    begin
      $display("No write-back burst was seen in the write-back test");
      errors++;
    end
    report_test("dirty_write_back", e);

    // Fill set 7, reorder the ages, then bring in a fifth line
    e = errors;
    for (int t = 1; t <= 4; t++)
      access($sformatf("lru_fill_%0d", t), 1'b0, addr_t'((t << 10) | (7 << 6)), '0, '0);
    access("lru_c", 1'b0, addr_t'((3 << 10) | (7 << 6)), '0, '0);
    access("lru_a", 1'b0, addr_t'((1 << 10) | (7 << 6)), '0, '0);
    access("lru_d", 1'b0, addr_t'((4 << 10) | (7 << 6)), '0, '0);
    access("lru_b", 1'b0, addr_t'((2 << 10) | (7 << 6)), '0, '0);
    access("lru_e", 1'b0, addr_t'((5 << 10) | (7 << 6)), '0, '0);
    for (int t = 1; t <= 4; t++)
      access($sformatf("lru_probe_%0d", t), 1'b0, addr_t'((t << 10) | (7 << 6)), '0, '0);
    report_test("lru_victim", e);

    e = errors;
    gap_en = 1'b1;
    for (int n = 0; n < 60; n++)
    begin
      r = lcg_next();
      a = addr_t'(((8 + r[2:0] % 6) << 10) | ((3 + r[3]) << 6) | (r[7:4] << 2));
      r = lcg_next();
      access($sformatf("traffic_%0d", n), r[0], a, lcg_next(), byte_en_t'(r[7:4]));
    end
    report_test("back_pressure", e);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// File: dcache.f
+incdir+logic
logic/dcache_pkg.sv
logic/line_buf_if.sv
logic/set_ram.sv
logic/lru_table.sv
logic/beat_counter.sv
logic/line_buffer.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
dv/mem_model.sv
dv/tb_dcache.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the data cache testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f dcache.f --top-module tb_dcache -o sim_dcache

./obj_dir/sim_dcache > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failures found" sim.log; then
  exit 1
fi
if ! grep -q "All tests passed!" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0
